// File: Bender.yml
package:
  name: dsp_io

sources:
  - logic/dsp_io_pkg.sv
  - logic/adc_frontend.sv
  - logic/dac_sum_sat.sv
  - logic/dac_moving_avg.sv
  - logic/dac_output_stage.sv
  - logic/dsp_io_top.sv
  - target: simulation
    files:
      - bench/tb_dsp_io_stim.sv
      - bench/tb_dsp_io.sv

// File: all.f
logic/dsp_io_pkg.sv
logic/adc_frontend.sv
logic/dac_sum_sat.sv
logic/dac_moving_avg.sv
logic/dac_output_stage.sv
logic/dsp_io_top.sv
bench/tb_dsp_io_stim.sv
bench/tb_dsp_io.sv

// File: bench/tb_dsp_io.sv
//////////////////////////////////////////////////////////////////////
// Analog data path testbench
// Clock, reset, DUT, reference model and concurrent checks, with a
// watchdog and the end of run report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_dsp_io;

  import dsp_io_pkg::*;

  localparam int        CLK_PERIOD  = 4;     // ns
  localparam int        RST_CYCLES  = 16;
  localparam int        TEST_CYCLES = 1600;  // All phases after reset
  localparam int        WATCHDOG_NS = 2 * (RST_CYCLES + TEST_CYCLES) * CLK_PERIOD;
  localparam int        HIST_DEPTH  = 64;    // Averaging window
  localparam dac_code_t MID_CODE    = 14'h1FFF;

  logic      adc_clk;
  logic      adc_rstn;
  adc_raw_t  adc_dat_a;
  adc_raw_t  adc_dat_b;
  sample_t   gen_a;
  sample_t   gen_b;
  sample_t   ctrl_a;
  sample_t   ctrl_b;
  logic      digital_loop;
  sample_t   adc_a;
  sample_t   adc_b;
  dac_code_t dac_dat_a;
  dac_code_t dac_dat_b;

  // Phase flags from the stimulus
  logic rst_chk;
  logic cap_chk;
  logic loop_chk;
  logic sat_chk;
  logic avg_chk;
  logic settle_chk;
  logic stim_done;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  sample_t   sat_ref_a;               // Expected clamped sums
  sample_t   sat_ref_b;
  dac_code_t raw_ref_a_q;             // Upper raw bits, one cycle late
  dac_code_t raw_ref_b_q;
  sample_t   exp_adc_a;
  sample_t   exp_adc_b;
  dac_code_t exp_dac_a_q;             // Expected pin codes
  dac_code_t exp_dac_b_q;
  sample_t   hist_q [HIST_DEPTH];     // Newest CH A sample at index 0

  // Top bit stays, lower 13 bits inverted, same both ways
  function automatic dac_code_t convert_offset(input logic [SAMPLE_W-1:0] code);
    return code ^ 14'h1FFF;
  endfunction

  function automatic sample_t clamp_sample(input int s);
    if (s > 8191) begin
      return sample_t'(8191);
    end else if (s < -8192) begin
      return sample_t'(-8192);
    end
    return sample_t'(s);
  endfunction

  function automatic int floor_div(input int num, input int den);
    int q;
    q = num / den;                      // Truncates toward zero
    if ((num % den != 0) && (num < 0)) begin
      q = q - 1;                        // Round negative quotients down
    end
    return q;
  endfunction

  task automatic report_mismatch(input string test_name,
                                 input logic [SAMPLE_W-1:0] expected,
                                 input logic [SAMPLE_W-1:0] actual);
    $display("error %s: expected %h, actual %h", test_name, expected, actual);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  assign sat_ref_a = clamp_sample(int'(gen_a) + int'(ctrl_a));
  assign sat_ref_b = clamp_sample(int'(gen_b) + int'(ctrl_b));
  assign exp_adc_a = digital_loop ? sat_ref_a : sample_t'(convert_offset(raw_ref_a_q));
  assign exp_adc_b = digital_loop ? sat_ref_b : sample_t'(convert_offset(raw_ref_b_q));

  always_ff @(posedge adc_clk) begin
    int win_sum;
    win_sum = 0;
    for (int i = 0; i < HIST_DEPTH; i++) begin
      win_sum += int'(hist_q[i]);       // Window up to the previous edge
    end
    if (!adc_rstn) begin
      raw_ref_a_q <= '0;
      raw_ref_b_q <= '0;
      exp_dac_a_q <= MID_CODE;
      exp_dac_b_q <= MID_CODE;
      for (int i = 0; i < HIST_DEPTH; i++) begin
        hist_q[i] <= '0;                // Old samples count as zero
      end
    end else begin
      raw_ref_a_q <= adc_dat_a[15:2];   // Two low bits ignored
      raw_ref_b_q <= adc_dat_b[15:2];
      hist_q[0]   <= sat_ref_a;
      for (int i = 1; i < HIST_DEPTH; i++) begin
        hist_q[i] <= hist_q[i-1];
      end
      exp_dac_a_q <= convert_offset(sample_t'(floor_div(win_sum, HIST_DEPTH)));
      exp_dac_b_q <= convert_offset(sat_ref_b);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_reset_a : assert property (@(posedge adc_clk) rst_chk |-> dac_dat_a == MID_CODE)
    else report_mismatch("reset dac a", MID_CODE, $sampled(dac_dat_a));
  a_reset_b : assert property (@(posedge adc_clk) rst_chk |-> dac_dat_b == MID_CODE)
    else report_mismatch("reset dac b", MID_CODE, $sampled(dac_dat_b));
  a_capture_a : assert property (@(posedge adc_clk) cap_chk |-> adc_a == exp_adc_a)
    else report_mismatch("adc capture a", $sampled(exp_adc_a), $sampled(adc_a));
  a_capture_b : assert property (@(posedge adc_clk) cap_chk |-> adc_b == exp_adc_b)
    else report_mismatch("adc capture b", $sampled(exp_adc_b), $sampled(adc_b));
  a_loop_a : assert property (@(posedge adc_clk) loop_chk |-> adc_a == sat_ref_a)
    else report_mismatch("loopback a", $sampled(sat_ref_a), $sampled(adc_a));
  a_loop_b : assert property (@(posedge adc_clk) loop_chk |-> adc_b == sat_ref_b)
    else report_mismatch("loopback b", $sampled(sat_ref_b), $sampled(adc_b));
  a_sat_b : assert property (@(posedge adc_clk) sat_chk |-> dac_dat_b == exp_dac_b_q)
    else report_mismatch("saturation b", $sampled(exp_dac_b_q), $sampled(dac_dat_b));
  a_avg_a : assert property (@(posedge adc_clk) avg_chk |-> dac_dat_a == exp_dac_a_q)
    else report_mismatch("average a", $sampled(exp_dac_a_q), $sampled(dac_dat_a));
  // Full window of one level gives that level back
  a_settle_a : assert property (
    @(posedge adc_clk) settle_chk |-> dac_dat_a == convert_offset(sat_ref_a)
  ) else report_mismatch("settled average a", convert_offset($sampled(sat_ref_a)),
                         $sampled(dac_dat_a));

  //////////////////////////////////////////////////////////////////////
  // DUT and stimulus
  //////////////////////////////////////////////////////////////////////

  dsp_io_top u_dsp_io_top (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_dat_a_i    (adc_dat_a),
    .adc_dat_b_i    (adc_dat_b),
    .gen_a_i        (gen_a),
    .gen_b_i        (gen_b),
    .ctrl_a_i       (ctrl_a),
    .ctrl_b_i       (ctrl_b),
    .digital_loop_i (digital_loop),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a),
    .dac_dat_b_o    (dac_dat_b)
  );

  tb_dsp_io_stim u_stim (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_dat_a_o    (adc_dat_a),
    .adc_dat_b_o    (adc_dat_b),
    .gen_a_o        (gen_a),
    .gen_b_o        (gen_b),
    .ctrl_a_o       (ctrl_a),
    .ctrl_b_o       (ctrl_b),
    .digital_loop_o (digital_loop),
    .rst_chk_o      (rst_chk),
    .cap_chk_o      (cap_chk),
    .loop_chk_o     (loop_chk),
    .sat_chk_o      (sat_chk),
    .avg_chk_o      (avg_chk),
    .settle_chk_o   (settle_chk),
    .done_o         (stim_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Clock, reset, watchdog, report
  //////////////////////////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  initial begin
    adc_rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    #1 adc_rstn = 1'b1;                 // Released like any other input
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    wait (stim_done === 1'b1);
    @(posedge adc_clk);                 // Let the last sample settle
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : tb_dsp_io

`default_nettype wire

// File: bench/tb_dsp_io_stim.sv
//////////////////////////////////////////////////////////////////////
// Stimulus for the analog data path testbench
// Drives the reset, capture, loopback, saturation and averaging
// phases and raises a flag for each active check
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_dsp_io_stim (
  input  wire logic            adc_clk,
  input  wire logic            adc_rstn,
  output dsp_io_pkg::adc_raw_t adc_dat_a_o,
  output dsp_io_pkg::adc_raw_t adc_dat_b_o,
  output dsp_io_pkg::sample_t  gen_a_o,
  output dsp_io_pkg::sample_t  gen_b_o,
  output dsp_io_pkg::sample_t  ctrl_a_o,
  output dsp_io_pkg::sample_t  ctrl_b_o,
  output logic                 digital_loop_o,
  output logic                 rst_chk_o,     // Phase flags
  output logic                 cap_chk_o,
  output logic                 loop_chk_o,
  output logic                 sat_chk_o,
  output logic                 avg_chk_o,
  output logic                 settle_chk_o,  // Window full of one level
  output logic                 done_o
);

  import dsp_io_pkg::*;

  localparam int SEED         = 44382;
  localparam int DRIVE_DLY    = 1;    // ns after the rising edge
  localparam int CAP_CYCLES   = 300;
  localparam int LOOP_CYCLES  = 300;
  localparam int SAT_CYCLES   = 300;
  localparam int CONST_CYCLES = 100;  // Per constant level
  localparam int SETTLE_AFTER = 70;   // 64 samples plus pipeline
  localparam int RAND_CYCLES  = 500;

  task automatic next_edge();
    @(posedge adc_clk);
    #DRIVE_DLY;
  endtask

  function automatic sample_t random_sample();
    logic [31:0] r;
    r = $urandom;
    return r[SAMPLE_W-1:0];
  endfunction

  function automatic adc_raw_t random_raw();
    logic [31:0] r;
    r = $urandom;
    return r[ADC_RAW_W-1:0];  // Low bits random too
  endfunction

  task automatic drive_random();
    gen_a_o  = random_sample();
    gen_b_o  = random_sample();
    ctrl_a_o = random_sample();
    ctrl_b_o = random_sample();
  endtask

  // Same operands on both channels
  task automatic drive_pair(input int gen_val, input int ctrl_val);
    gen_a_o  = sample_t'(gen_val);
    gen_b_o  = sample_t'(gen_val);
    ctrl_a_o = sample_t'(ctrl_val);
    ctrl_b_o = sample_t'(ctrl_val);
  endtask

  task automatic drive_extreme(input int idx);
    case (idx)
      0:       drive_pair(8191, 8191);    // Positive overflow
      1:       drive_pair(-8192, -8192);  // Negative overflow
      2:       drive_pair(8191, 1);
      3:       drive_pair(-8192, -1);
      4:       drive_pair(8191, -8192);   // Opposite full scales
      5:       drive_pair(4096, 4095);    // Lands on +full scale
      6:       drive_pair(-4096, -4096);  // Lands on -full scale
      default: drive_pair(5000, 5000);
    endcase
  endtask

  task automatic hold_constant(input int gen_val, input int ctrl_val);
    gen_a_o  = sample_t'(gen_val);
    ctrl_a_o = sample_t'(ctrl_val);
    for (int j = 0; j < CONST_CYCLES; j++) begin
      settle_chk_o = (j >= SETTLE_AFTER);
      next_edge();
    end
    settle_chk_o = 1'b0;  // Dropped before the level changes
  endtask

  initial begin
    void'($urandom(SEED));  // Seeds the generator once
    adc_dat_a_o    = '0;
    adc_dat_b_o    = '0;
    drive_pair(0, 0);
    digital_loop_o = 1'b0;
    rst_chk_o      = 1'b0;
    cap_chk_o      = 1'b0;
    loop_chk_o     = 1'b0;
    sat_chk_o      = 1'b0;
    avg_chk_o      = 1'b0;
    settle_chk_o   = 1'b0;
    done_o         = 1'b0;

    // Reset, checked through the first cycle after release
    next_edge();
    rst_chk_o = 1'b1;
    drive_pair(3000, 1000);  // Nonzero sums while reset is held
    wait (adc_rstn === 1'b1);
    drive_pair(0, 0);
    next_edge();
    next_edge();
    rst_chk_o = 1'b0;

    cap_chk_o = 1'b1;
    repeat (CAP_CYCLES) begin
      adc_dat_a_o = random_raw();
      adc_dat_b_o = random_raw();
      next_edge();
    end
    cap_chk_o = 1'b0;

    digital_loop_o = 1'b1;
    loop_chk_o     = 1'b1;
    repeat (LOOP_CYCLES) begin
      drive_random();
      next_edge();
    end
    loop_chk_o     = 1'b0;
    digital_loop_o = 1'b0;

    // Extremes every fourth cycle, random in between
    sat_chk_o = 1'b1;
    for (int i = 0; i < SAT_CYCLES; i++) begin
      if (i % 4 == 0) begin
        drive_extreme((i / 4) % 8);
      end else begin
        drive_random();
      end
      next_edge();
    end
    sat_chk_o = 1'b0;

    avg_chk_o = 1'b1;
    hold_constant(3000, 1234);    // In range level
    hold_constant(-6000, -3000);  // Clamped level
    repeat (RAND_CYCLES) begin
      drive_random();
      next_edge();
    end
    avg_chk_o = 1'b0;
    done_o    = 1'b1;
  end

endmodule : tb_dsp_io_stim

`default_nettype wire

// File: logic/adc_frontend.sv
//////////////////////////////////////////////////////////////////////
// ADC front end
// Registers both raw ADC words, drops the two low bits, converts the
// offset code to two's complement and applies the digital loopback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module adc_frontend (
  input  wire logic                 adc_clk,
  input  wire logic                 adc_rstn,        // Sync, active low
  input  wire dsp_io_pkg::adc_raw_t adc_dat_a_i,     // Raw word CH A
  input  wire dsp_io_pkg::adc_raw_t adc_dat_b_i,     // Raw word CH B
  input  wire dsp_io_pkg::sample_t  loop_a_i,        // DAC side sample CH A
  input  wire dsp_io_pkg::sample_t  loop_b_i,        // DAC side sample CH B
  input  wire logic                 digital_loop_i,  // Loopback select
  output dsp_io_pkg::sample_t       adc_a_o,
  output dsp_io_pkg::sample_t       adc_b_o
);

  import dsp_io_pkg::*;

  dac_code_t raw_a_q;   // Upper raw bits in offset code
  dac_code_t raw_b_q;
  sample_t   conv_a;    // After code flip
  sample_t   conv_b;

  //////////////////////////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////////////////////////

  // Low two bits of the 16 bit word carry nothing for a 14 bit ADC
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_dat_a_i[ADC_RAW_W-1 -: SAMPLE_W];
      raw_b_q <= adc_dat_b_i[ADC_RAW_W-1 -: SAMPLE_W];
    end
  end

  // Negative slope offset code to two's complement
  assign conv_a = flip_code(raw_a_q);
  assign conv_b = flip_code(raw_b_q);

  // Loopback bypasses the register
  assign adc_a_o = digital_loop_i ? loop_a_i : conv_a;
  assign adc_b_o = digital_loop_i ? loop_b_i : conv_b;

  // Capture path shows the previous raw word converted
  a_capture_latency : assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    $past(adc_rstn) && !digital_loop_i |->
      (adc_a_o == sample_t'(flip_code($past(adc_dat_a_i[ADC_RAW_W-1 -: SAMPLE_W])))) &&
      (adc_b_o == sample_t'(flip_code($past(adc_dat_b_i[ADC_RAW_W-1 -: SAMPLE_W]))))
  ) else $error("adc_frontend: converted sample does not match the raw word");

endmodule : adc_frontend

`default_nettype wire

// File: logic/dac_moving_avg.sv
//////////////////////////////////////////////////////////////////////
// Moving average for DAC channel A
// Ring buffer of the last 2**AVG_LOG2 samples with a running sum,
// the average is the sum shifted down arithmetically
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dac_moving_avg #(
  parameter int unsigned AVG_LOG2 = dsp_io_pkg::AVG_LOG2_DEF  // log2 of depth
) (
  input  wire logic                adc_clk,
  input  wire logic                adc_rstn,  // Sync, active low
  input  wire dsp_io_pkg::sample_t sample_i,  // Saturated CH A sample
  output dsp_io_pkg::sample_t      avg_o      // Average incl. latest sample
);

  import dsp_io_pkg::*;

  localparam int unsigned DEPTH = 1 << AVG_LOG2;        // Ring entries
  localparam int unsigned SUM_W = SAMPLE_W + AVG_LOG2;  // No overflow possible

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  sample_t                 ring_q [DEPTH];  // Sample history
  logic [AVG_LOG2-1:0]     idx_q;           // Slot of the oldest sample
  logic signed [SUM_W-1:0] sum_q;           // Sum over the whole ring
  logic signed [SUM_W-1:0] sum_shift;
  logic signed [SUM_W-1:0] ring_total;      // Ring contents added up
  sample_t                 oldest;

  assign oldest = ring_q[idx_q];

  //////////////////////////////////////////////////////////////////////
  // Ring and running sum
  //////////////////////////////////////////////////////////////////////

  // Cleared history counts as zero samples after reset
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int i = 0; i < DEPTH; i++) begin
        ring_q[i] <= '0;
      end
      idx_q <= '0;
      sum_q <= '0;
    end else begin
      sum_q         <= sum_q + sample_i - oldest;  // Add new, drop oldest
      ring_q[idx_q] <= sample_i;                   // New overwrites oldest
      idx_q         <= idx_q + 1'b1;               // Wraps at the ring depth
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Average
  //////////////////////////////////////////////////////////////////////

  // Arithmetic shift gives the floor of sum / DEPTH
  assign sum_shift = sum_q >>> AVG_LOG2;
  assign avg_o     = sum_shift[SAMPLE_W-1:0];  // Always fits the sample range

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ring_total = '0;
    for (int i = 0; i < DEPTH; i++) begin
      ring_total = ring_total + ring_q[i];
    end
  end

  // Running sum tracks the ring contents
  a_sum_matches_ring : assert property (
    @(posedge adc_clk) disable iff (!adc_rstn) sum_q == ring_total
  ) else $error("dac_moving_avg: running sum differs from ring contents");

  // Sum starts from an empty history
  a_sum_clear : assert property (
    @(posedge adc_clk) $rose(adc_rstn) |-> (sum_q == '0)
  ) else $error("dac_moving_avg: running sum not cleared by reset");

endmodule : dac_moving_avg

`default_nettype wire

// File: logic/dac_output_stage.sv
//////////////////////////////////////////////////////////////////////
// DAC output stage
// Converts both channel samples to negative slope offset code in
// output registers that come out of reset at mid-scale
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dac_output_stage (
  input  wire logic                adc_clk,
  input  wire logic                adc_rstn,     // Sync, active low
  input  wire dsp_io_pkg::sample_t dac_a_i,      // Averaged CH A
  input  wire dsp_io_pkg::sample_t dac_b_i,      // Saturated CH B
  output dsp_io_pkg::dac_code_t    dac_dat_a_o,  // Pin code CH A
  output dsp_io_pkg::dac_code_t    dac_dat_b_o   // Pin code CH B
);

  import dsp_io_pkg::*;

  // Code of sample zero
  localparam dac_code_t DAC_MID = {1'b0, {(SAMPLE_W-1){1'b1}}};

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  // Converter sits at mid-scale while in reset
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_dat_a_o <= DAC_MID;
      dac_dat_b_o <= DAC_MID;
    end else begin
      dac_dat_a_o <= flip_code(dac_a_i);  // Two's complement to offset code
      dac_dat_b_o <= flip_code(dac_b_i);
    end
  end

  // First cycle out of reset still shows mid-scale on both pins
  a_mid_after_reset : assert property (
    @(posedge adc_clk) $rose(adc_rstn) |->
      (dac_dat_a_o == DAC_MID) && (dac_dat_b_o == DAC_MID)
  ) else $error("dac_output_stage: outputs not mid-scale after reset");

endmodule : dac_output_stage

`default_nettype wire

// File: logic/dac_sum_sat.sv
//////////////////////////////////////////////////////////////////////
// DAC summer
// Adds generator and controller samples per channel and clamps the
// result to the 14 bit sample range
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dac_sum_sat (
  input  wire dsp_io_pkg::sample_t gen_a_i,   // Generator CH A
  input  wire dsp_io_pkg::sample_t gen_b_i,   // Generator CH B
  input  wire dsp_io_pkg::sample_t ctrl_a_i,  // Controller CH A
  input  wire dsp_io_pkg::sample_t ctrl_b_i,  // Controller CH B
  output dsp_io_pkg::sample_t      sat_a_o,
  output dsp_io_pkg::sample_t      sat_b_o
);

  import dsp_io_pkg::*;

  localparam int SAMPLE_MAX = (1 << (SAMPLE_W-1)) - 1;  // 8191
  localparam int SAMPLE_MIN = -(1 << (SAMPLE_W-1));     // -8192

  logic signed [SAMPLE_W:0] sum_a;  // One guard bit
  logic signed [SAMPLE_W:0] sum_b;

  // Top two bits differ on overflow, sign bit tells the direction
  function automatic sample_t saturate(input logic signed [SAMPLE_W:0] s);
    sample_t res;
    if (s[SAMPLE_W] != s[SAMPLE_W-1]) begin
      res = {s[SAMPLE_W], {(SAMPLE_W-1){~s[SAMPLE_W]}}};  // Full scale
    end else begin
      res = s[SAMPLE_W-1:0];
    end
    return res;
  endfunction

  // Operands sign extended to the sum width
  assign sum_a = gen_a_i + ctrl_a_i;
  assign sum_b = gen_b_i + ctrl_b_i;

  assign sat_a_o = saturate(sum_a);
  assign sat_b_o = saturate(sum_b);

  // In range sums pass unchanged
  always_comb begin
    a_sum_a_passes : assert final (
      (sum_a < SAMPLE_MIN) || (sum_a > SAMPLE_MAX) || (sat_a_o == sum_a[SAMPLE_W-1:0])
    ) else $error("dac_sum_sat: CH A in range sum altered");
    a_sum_b_passes : assert final (
      (sum_b < SAMPLE_MIN) || (sum_b > SAMPLE_MAX) || (sat_b_o == sum_b[SAMPLE_W-1:0])
    ) else $error("dac_sum_sat: CH B in range sum altered");
  end

endmodule : dac_sum_sat

`default_nettype wire

// File: logic/dsp_io_pkg.sv
//////////////////////////////////////////////////////////////////////
// Analog data path definitions
// Sample widths, vector types and the offset code conversion shared
// by the ADC front end and the DAC output stage
//////////////////////////////////////////////////////////////////////

`default_nettype none

package dsp_io_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_RAW_W = 16;  // Raw ADC pin word
  localparam int unsigned SAMPLE_W  = 14;  // Signal sample

  // Averaging depth is 2**AVG_LOG2_DEF samples
  localparam int unsigned AVG_LOG2_DEF = 6;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // Word as seen on the ADC pins, two low bits unused
  typedef logic [ADC_RAW_W-1:0] adc_raw_t;

  // Two's complement signal sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Negative slope offset code at the converter pins
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  //////////////////////////////////////////////////////////////////////
  // Code conversion
  //////////////////////////////////////////////////////////////////////

  // Offset code <-> two's complement
  // Top bit kept, rest inverted; applying it twice gives the input back
  // Sample zero maps to 1FFF, the mid-scale code
  function automatic logic [SAMPLE_W-1:0] flip_code(
    input logic [SAMPLE_W-1:0] code
  );
    logic [SAMPLE_W-1:0] res;
    res[SAMPLE_W-1]   = code[SAMPLE_W-1];   // Sign position unchanged
    res[SAMPLE_W-2:0] = ~code[SAMPLE_W-2:0]; // Magnitude bits inverted
    return res;
  endfunction

endpackage : dsp_io_pkg

`default_nettype wire

// File: logic/dsp_io_top.sv
//////////////////////////////////////////////////////////////////////
// Analog data path top level
// ADC capture with loopback, DAC summing with saturation, moving
// average on channel A and DAC code conversion, all on adc_clk
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dsp_io_top #(
  parameter int unsigned AVG_LOG2 = dsp_io_pkg::AVG_LOG2_DEF  // CH A average depth
) (
  input  wire logic                 adc_clk,
  input  wire logic                 adc_rstn,        // Sync, active low
  // ADC pins
  input  wire dsp_io_pkg::adc_raw_t adc_dat_a_i,
  input  wire dsp_io_pkg::adc_raw_t adc_dat_b_i,
  // Generator and controller samples
  input  wire dsp_io_pkg::sample_t  gen_a_i,
  input  wire dsp_io_pkg::sample_t  gen_b_i,
  input  wire dsp_io_pkg::sample_t  ctrl_a_i,
  input  wire dsp_io_pkg::sample_t  ctrl_b_i,
  input  wire logic                 digital_loop_i,  // DAC samples into ADC path
  // Toward scope and controller
  output dsp_io_pkg::sample_t       adc_a_o,
  output dsp_io_pkg::sample_t       adc_b_o,
  // DAC pins
  output dsp_io_pkg::dac_code_t     dac_dat_a_o,
  output dsp_io_pkg::dac_code_t     dac_dat_b_o
);

  import dsp_io_pkg::*;

  sample_t sat_a;  // Clamped sums
  sample_t sat_b;
  sample_t avg_a;  // CH A after averaging

  //////////////////////////////////////////////////////////////////////
  // ADC side
  //////////////////////////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .loop_a_i       (sat_a),           // Loopback source
    .loop_b_i       (sat_b),
    .digital_loop_i (digital_loop_i),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  //////////////////////////////////////////////////////////////////////
  // DAC side
  //////////////////////////////////////////////////////////////////////

  dac_sum_sat u_dac_sum_sat (
    .gen_a_i  (gen_a_i),
    .gen_b_i  (gen_b_i),
    .ctrl_a_i (ctrl_a_i),
    .ctrl_b_i (ctrl_b_i),
    .sat_a_o  (sat_a),
    .sat_b_o  (sat_b)
  );

  dac_moving_avg #(
    .AVG_LOG2 (AVG_LOG2)
  ) u_dac_moving_avg (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .sample_i (sat_a),
    .avg_o    (avg_a)
  );

  // CH B goes straight from the summer
  dac_output_stage u_dac_output_stage (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .dac_a_i     (avg_a),
    .dac_b_i     (sat_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule : dsp_io_top

`default_nettype wire
